// ==== flist.f ====
hw/mem_pkg.sv
hw/mem_cmd_if.sv
hw/wr_data_fifo.sv
hw/rd_prefetch_fifo.sv
hw/burst_ram.sv
hw/mem_port_fsm.sv
hw/wb_mem_bridge.sv
sim/tb_wb_mem_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then search the log for the fail line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_mem_bridge -f flist.f \
   && ./obj_dir/Vtb_wb_mem_bridge > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

// ==== sim/tb_wb_mem_bridge.sv ====
`timescale 1ns/1ns

module tb_wb_mem_bridge;

   localparam int READ_BURST_LEN = mem_pkg::DEF_READ_BURST_LEN;
   localparam int MEM_AWORDS     = mem_pkg::DEF_MEM_AWORDS;
   localparam int NUM_TESTS      = 17;

   localparam logic [1:0] OP_WR  = 2'd0;
   localparam logic [1:0] OP_RD  = 2'd1;
   localparam logic [1:0] OP_INV = 2'd2;  // external read-ahead flush

   typedef struct packed {
      logic [1:0]          op;
      mem_pkg::byte_addr_t addr;  // first byte of the block
      logic [7:0]          cnt;   // words in the block
      mem_pkg::sel_t       sel;   // lanes used by every word of a write
   } test_t;

   localparam test_t TESTS [NUM_TESTS] = '{
      '{OP_WR,  29'h000, 8'd40, 4'hf},                      // base data, words 0..39
      '{OP_RD,  29'h000, 8'd1, 4'hf},
      '{OP_RD,  29'h040, 8'(READ_BURST_LEN), 4'hf},
      '{OP_RD,  29'h004, 8'(3 * READ_BURST_LEN + 2), 4'hf}, // crosses refills
      '{OP_WR,  29'h008, 8'd4, 4'h3},                       // low lanes only
      '{OP_WR,  29'h014, 8'd3, 4'hc},                       // high lanes only
      '{OP_RD,  29'h000, 8'd10, 4'hf},
      '{OP_RD,  29'h080, 8'd2, 4'hf},
      '{OP_RD,  29'h088, 8'd3, 4'hf},                       // read-ahead hit
      '{OP_RD,  29'h030, 8'd4, 4'hf},                       // unrelated address
      '{OP_WR,  29'h044, 8'd2, 4'hf},                       // lands in read-ahead range
      '{OP_RD,  29'h040, 8'd4, 4'hf},
      '{OP_RD,  29'h000, 8'd2, 4'hf},
      '{OP_INV, 29'h008, 8'd3, 4'hf},                       // memory changed behind the bridge
      '{OP_RD,  29'h008, 8'd3, 4'hf},
      '{OP_WR,  29'h200, 8'd100, 4'hf},                     // longer than the write fifo
      '{OP_RD,  29'h200, 8'd100, 4'hf}
   };

   logic                wb_clk;
   logic                mem_rst;
   logic                cyc;
   logic                stb;
   logic                we;
   mem_pkg::sel_t       sel;
   mem_pkg::byte_addr_t addr;
   mem_pkg::data_t      dat_w;
   logic                inv_req;
   logic                ack;
   logic                stall;
   mem_pkg::data_t      dat_r;

   mem_pkg::data_t model [2**MEM_AWORDS];  // expected memory contents
   logic [31:0]    rnd = 32'd86970;       // data generator state
   int             err_cnt = 0;
   int             chk_cnt = 0;
   logic           stalled;

   wb_mem_bridge #(
      .READ_BURST_LEN (READ_BURST_LEN),
      .MEM_AWORDS     (MEM_AWORDS)
   ) u_wb_mem_bridge (
      .wb_clk      (wb_clk),
      .mem_rst     (mem_rst),
      .wbm_cyc_i   (cyc),
      .wbm_stb_i   (stb),
      .wbm_we_i    (we),
      .wbm_sel_i   (sel),
      .wbm_addr_i  (addr),
      .wbm_dat_i   (dat_w),
      .inv_req_i   (inv_req),
      .wbm_ack_o   (ack),
      .wbm_stall_o (stall),
      .wbm_dat_o   (dat_r)
   );

   initial begin
      wb_clk = 1'b0;
      forever #50 wb_clk = ~wb_clk;  // 100 ns period
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // same word address bits as the memory, wraps with its size
   function automatic int word_index(input mem_pkg::byte_addr_t a);
      return int'(a[MEM_AWORDS+1:2]);
   endfunction

   ////////////////////////////////////////////////////////////
   // bus master tasks, sample at negedge, drive 10 ns after posedge
   ////////////////////////////////////////////////////////////
   task automatic write_block(input mem_pkg::byte_addr_t start, input int n,
                              input mem_pkg::sel_t lanes, output logic saw_stall);
      int   issued;
      int   acks;
      logic acc;
      logic acc_d;  // strobe taken at the previous edge
      issued    = 0;
      acks      = 0;
      acc_d     = 1'b0;
      saw_stall = 1'b0;
      rnd       = xorshift32(rnd);
      cyc       = 1'b1;
      stb       = 1'b1;
      we        = 1'b1;
      addr      = start;
      dat_w     = rnd;
      sel       = lanes;
      while (acks < n) begin
         @(negedge wb_clk);
         chk_cnt++;
         assert (ack == acc_d) else begin
            err_cnt++;
            $display("Error %0t ns: write ack is %0b, expected %0b", $time, ack, acc_d);
         end
         if (ack) acks++;
         if (stall) saw_stall = 1'b1;
         acc   = stb & ~stall;
         acc_d = acc;
         @(posedge wb_clk);
         #10;
         if (acc) begin
            for (int b = 0; b < 4; b++) begin
               if (sel[b]) model[word_index(addr)][8*b +: 8] = dat_w[8*b +: 8];  // lane merge
            end
            issued++;
            if (issued < n) begin
               addr  = addr + 29'd4;
               rnd   = xorshift32(rnd);
               dat_w = rnd;
            end else begin
               stb = 1'b0;
            end
         end
      end
      cyc = 1'b0;
      we  = 1'b0;
   endtask

   task automatic read_block(input mem_pkg::byte_addr_t start, input int n);
      mem_pkg::byte_addr_t pend [$];  // accepted strobes, oldest first
      mem_pkg::byte_addr_t a;
      mem_pkg::data_t      exp;
      int                  issued;
      int                  got;
      logic                acc;
      issued = 0;
      got    = 0;
      cyc    = 1'b1;
      stb    = 1'b1;
      we     = 1'b0;
      addr   = start;
      while (got < n) begin
         @(negedge wb_clk);
         if (ack) begin
            got++;
            chk_cnt++;
            assert (pend.size() != 0) else begin
               err_cnt++;
               $display("A read ack at %0t ns came with no strobe outstanding", $time);
            end
            if (pend.size() != 0) begin
               a   = pend.pop_front();
               exp = model[word_index(a)];
               assert (dat_r == exp) else begin
                  err_cnt++;
                  $display("Error %0t ns: read at 0x%h returned %h, expected %h",
                           $time, a, dat_r, exp);
               end
            end
         end
         acc = stb & ~stall;
         @(posedge wb_clk);
         #10;
         if (acc) begin
            pend.push_back(addr);
            issued++;
            if (issued < n) addr = addr + 29'd4;  // pipelined, sequential
            else stb = 1'b0;
         end
      end
      cyc = 1'b0;
   endtask

   // another writer changes the memory, then the read-ahead is flushed
   task automatic pulse_invalidate(input mem_pkg::byte_addr_t start, input int n);
      mem_pkg::byte_addr_t a;
      a = start;
      for (int i = 0; i < n; i++) begin
         rnd = xorshift32(rnd);
         model[word_index(a)] = rnd;
         u_wb_mem_bridge.u_burst_ram.mem[word_index(a)] = rnd;  // bypasses the bus
         a = a + 29'd4;
      end
      inv_req = 1'b1;
      @(posedge wb_clk);
      #10;
      inv_req = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////
   initial begin
      mem_rst = 1'b1;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      sel     = '0;
      addr    = '0;
      dat_w   = '0;
      inv_req = 1'b0;
      repeat (16) @(posedge wb_clk);
      #10;
      mem_rst = 1'b0;
      @(negedge wb_clk);
      chk_cnt++;
      assert (!ack && !stall) else begin
         err_cnt++;
         $display("Error %0t ns: ack %0b stall %0b after reset", $time, ack, stall);
      end
      @(posedge wb_clk);
      #10;

      for (int t = 0; t < NUM_TESTS; t++) begin
         case (TESTS[t].op)
            OP_WR: begin
               write_block(TESTS[t].addr, int'(TESTS[t].cnt), TESTS[t].sel, stalled);
               if (int'(TESTS[t].cnt) > mem_pkg::FIFO_DEPTH) begin
                  chk_cnt++;
                  assert (stalled) else begin
                     err_cnt++;
                     $display("Stall never rose during the %0d word write", TESTS[t].cnt);
                  end
               end
            end
            OP_RD:   read_block(TESTS[t].addr, int'(TESTS[t].cnt));
            default: pulse_invalidate(TESTS[t].addr, int'(TESTS[t].cnt));
         endcase
         repeat (2) @(posedge wb_clk);  // idle gap, cycle closed
         #10;
      end

      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // run limit grows with the words in the table
   initial begin : watchdog
      int total;
      total = 0;
      for (int t = 0; t < NUM_TESTS; t++) total += int'(TESTS[t].cnt);
      repeat ((total + 50) * 40) @(posedge wb_clk);
      $display("Timeout, the run did not finish within %0d cycles", (total + 50) * 40);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== hw/wb_mem_bridge.sv ====
`timescale 1ns/1ns

module wb_mem_bridge #(
   parameter int READ_BURST_LEN = mem_pkg::DEF_READ_BURST_LEN,
   parameter int MEM_AWORDS     = mem_pkg::DEF_MEM_AWORDS
) (
   input  logic                wb_clk,
   input  logic                mem_rst,
   input  logic                wbm_cyc_i,
   input  logic                wbm_stb_i,
   input  logic                wbm_we_i,
   input  mem_pkg::sel_t       wbm_sel_i,
   input  mem_pkg::byte_addr_t wbm_addr_i,
   input  mem_pkg::data_t      wbm_dat_i,
   input  logic                inv_req_i,
   output logic                wbm_ack_o,
   output logic                wbm_stall_o,
   output mem_pkg::data_t      wbm_dat_o
);

   mem_cmd_if u_cmd_if ();

   // write fifo link
   logic           wr_push;
   logic           wr_pop;
   logic           wr_full;
   logic           wr_empty;
   mem_pkg::data_t wr_data;
   mem_pkg::sel_t  wr_sel;

   // read fifo link
   logic           rd_push;
   logic           rd_pop;
   logic           rd_full;
   logic           rd_empty;
   logic           rd_busy;   // stale words being dropped
   logic           rd_inv;
   mem_pkg::fcnt_t rd_inv_cnt;
   mem_pkg::data_t rd_wdata;  // memory to fifo
   mem_pkg::data_t rd_rdata;  // fifo head to FSM

   mem_port_fsm #(.READ_BURST_LEN(READ_BURST_LEN)) u_mem_port_fsm (
      .wb_clk       (wb_clk),
      .mem_rst      (mem_rst),
      .wbm_cyc_i    (wbm_cyc_i),
      .wbm_stb_i    (wbm_stb_i),
      .wbm_we_i     (wbm_we_i),
      .wbm_addr_i   (wbm_addr_i),
      .inv_req_i    (inv_req_i),
      .wbm_ack_o    (wbm_ack_o),
      .wbm_stall_o  (wbm_stall_o),
      .wbm_dat_o    (wbm_dat_o),
      .cmd          (u_cmd_if.issuer),
      .wr_full_i    (wr_full),
      .wr_push_o    (wr_push),
      .rd_data_i    (rd_rdata),
      .rd_empty_i   (rd_empty),
      .rd_busy_i    (rd_busy),
      .rd_pop_o     (rd_pop),
      .rd_inv_o     (rd_inv),
      .rd_inv_cnt_o (rd_inv_cnt)
   );

   // data and lanes come straight from the bus
   wr_data_fifo u_wr_data_fifo (
      .wb_clk  (wb_clk),
      .mem_rst (mem_rst),
      .push_i  (wr_push),
      .data_i  (wbm_dat_i),
      .sel_i   (wbm_sel_i),
      .pop_i   (wr_pop),
      .data_o  (wr_data),
      .sel_o   (wr_sel),
      .full_o  (wr_full),
      .empty_o (wr_empty)
   );

   rd_prefetch_fifo u_rd_prefetch_fifo (
      .wb_clk    (wb_clk),
      .mem_rst   (mem_rst),
      .push_i    (rd_push),
      .data_i    (rd_wdata),
      .pop_i     (rd_pop),
      .inv_i     (rd_inv),
      .inv_cnt_i (rd_inv_cnt),
      .data_o    (rd_rdata),
      .empty_o   (rd_empty),
      .full_o    (rd_full),
      .busy_o    (rd_busy)
   );

   burst_ram #(.MEM_AWORDS(MEM_AWORDS)) u_burst_ram (
      .wb_clk     (wb_clk),
      .mem_rst    (mem_rst),
      .cmd        (u_cmd_if.executor),
      .wr_data_i  (wr_data),
      .wr_sel_i   (wr_sel),
      .wr_empty_i (wr_empty),
      .wr_pop_o   (wr_pop),
      .rd_full_i  (rd_full),
      .rd_push_o  (rd_push),
      .rd_data_o  (rd_wdata)
   );

endmodule

// ==== hw/mem_port_fsm.sv ====
`timescale 1ns/1ns

module mem_port_fsm #(
   parameter int READ_BURST_LEN = mem_pkg::DEF_READ_BURST_LEN
) (
   input  logic                wb_clk,
   input  logic                mem_rst,
   input  logic                wbm_cyc_i,
   input  logic                wbm_stb_i,
   input  logic                wbm_we_i,
   input  mem_pkg::byte_addr_t wbm_addr_i,
   input  logic                inv_req_i,
   output logic                wbm_ack_o,
   output logic                wbm_stall_o,
   output mem_pkg::data_t      wbm_dat_o,
   mem_cmd_if.issuer           cmd,
   input  logic                wr_full_i,
   output logic                wr_push_o,
   input  mem_pkg::data_t      rd_data_i,
   input  logic                rd_empty_i,
   input  logic                rd_busy_i,
   output logic                rd_pop_o,
   output logic                rd_inv_o,
   output mem_pkg::fcnt_t      rd_inv_cnt_o
);

   mem_pkg::fsm_state_e state;
   mem_pkg::fcnt_t      stb_cnt;   // accepted strobes in this block
   mem_pkg::fcnt_t      ack_cnt;   // read acks given in this block
   mem_pkg::byte_addr_t adr_next;  // address of the word at the read fifo head
   mem_pkg::fcnt_t      rd_left;   // words issued for reading and not yet taken
   logic                acc;       // strobe accepted this cycle
   logic                pending;   // accepted reads still waiting for data
   logic                rd_ok;     // read fifo head may be used
   logic                hit;
   logic                rd_miss;
   logic                rd_refill;
   logic                blk_end;   // write block is complete

   ////////////////////////////////////////////////////////////
   // strobe handling
   ////////////////////////////////////////////////////////////
   // WR_CMD holds the master off, a strobe there would miss its block
   assign wbm_stall_o = wr_full_i | cmd.cmd_full | (state == mem_pkg::ST_WR_CMD);
   assign acc       = wbm_cyc_i & wbm_stb_i & ~wbm_stall_o;
   assign wr_push_o = acc & wbm_we_i;  // write words go straight to the fifo
   assign pending   = (stb_cnt != ack_cnt) | acc;

   // no use of the head while stale words may sit in front of it
   assign rd_ok = (rd_left != '0) & ~rd_busy_i & ~rd_inv_o & ~inv_req_i;
   assign hit   = rd_ok & (wbm_addr_i == adr_next);

   assign rd_pop_o = ~rd_empty_i & rd_ok &
                     (((state == mem_pkg::ST_IDLE) & acc & ~wbm_we_i & hit) |
                      ((state == mem_pkg::ST_RD_FIFO) & wbm_cyc_i & pending));

   assign rd_miss   = (state == mem_pkg::ST_IDLE) & acc & ~wbm_we_i & ~hit;
   assign rd_refill = (state == mem_pkg::ST_RD_FIFO) & wbm_cyc_i & pending &
                      (rd_left == '0);  // block ran dry

   assign blk_end = ~wbm_cyc_i | wr_full_i |
                    (acc & (stb_cnt == mem_pkg::fcnt_t'(mem_pkg::FIFO_DEPTH - 1)));

   ////////////////////////////////////////////////////////////
   // control state machine
   ////////////////////////////////////////////////////////////
   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         state      <= mem_pkg::ST_RST;
         wbm_ack_o  <= 1'b0;
         cmd.cmd_en <= 1'b0;
         rd_inv_o   <= 1'b0;
         rd_left    <= '0;
         stb_cnt    <= '0;
         ack_cnt    <= '0;
      end else begin
         wbm_ack_o    <= wr_push_o | rd_pop_o;  // writes ack one cycle later
         cmd.cmd_en   <= 1'b0;
         rd_inv_o     <= 1'b0;
         rd_inv_cnt_o <= rd_left;               // drop count rides with each inv pulse
         if (acc) stb_cnt <= stb_cnt + 1'b1;
         if (rd_pop_o) begin
            wbm_dat_o <= rd_data_i;
            ack_cnt   <= ack_cnt + 1'b1;
            rd_left   <= rd_left - 1'b1;
            adr_next  <= adr_next + 29'd4;
         end
         if (inv_req_i) begin
            rd_inv_o <= 1'b1;  // external request, all read-ahead goes
            rd_left  <= '0;
         end

         case (state)
            mem_pkg::ST_RST: begin
               if (!wbm_cyc_i) state <= mem_pkg::ST_IDLE;
            end
            mem_pkg::ST_IDLE: begin
               stb_cnt <= mem_pkg::fcnt_t'(acc);  // new block
               ack_cnt <= mem_pkg::fcnt_t'(rd_pop_o);
               if (acc) begin
                  cmd.cmd_addr <= wbm_addr_i;     // burst start
                  if (wbm_we_i) begin
                     state <= mem_pkg::ST_WR_FIFO;
                  end else if (hit) begin
                     state <= mem_pkg::ST_RD_FIFO;  // read-ahead reused
                  end else begin
                     adr_next <= wbm_addr_i;  // head once leftovers are drained
                     rd_inv_o <= 1'b1;
                  end
               end
            end
            mem_pkg::ST_WR_FIFO: begin
               if (blk_end) begin
                  cmd.cmd_instr <= mem_pkg::CMD_WRITE;
                  cmd.cmd_blen  <= mem_pkg::blen_t'(stb_cnt + mem_pkg::fcnt_t'(acc) - 1'b1);
                  rd_inv_o      <= 1'b1;  // read-ahead may now be stale
                  rd_left       <= '0;
                  if (cmd.cmd_full) begin
                     state <= mem_pkg::ST_WR_CMD;
                  end else begin
                     cmd.cmd_en <= 1'b1;
                     state      <= mem_pkg::ST_IDLE;
                  end
               end
            end
            mem_pkg::ST_WR_CMD: begin
               if (!cmd.cmd_full) begin
                  cmd.cmd_en <= 1'b1;
                  state      <= mem_pkg::ST_IDLE;
               end
            end
            mem_pkg::ST_RD_FIFO: begin
               if (rd_refill) cmd.cmd_addr <= adr_next;  // continue where the fifo ends
               if (!wbm_cyc_i) state <= mem_pkg::ST_IDLE;  // leftovers stay for a hit
            end
            mem_pkg::ST_RD_CMD: begin
               if (!cmd.cmd_full) begin
                  cmd.cmd_en <= 1'b1;  // burst prepared before
                  state      <= mem_pkg::ST_RD_FIFO;
               end
            end
            default: state <= mem_pkg::ST_RST;
         endcase

         // new read burst, shared by a miss and a refill
         if (rd_miss | rd_refill) begin
            cmd.cmd_instr <= mem_pkg::CMD_READ;
            cmd.cmd_blen  <= mem_pkg::blen_t'(READ_BURST_LEN - 1);
            rd_left       <= mem_pkg::fcnt_t'(READ_BURST_LEN);
            if (cmd.cmd_full) begin
               state <= mem_pkg::ST_RD_CMD;
            end else begin
               cmd.cmd_en <= 1'b1;
               state      <= mem_pkg::ST_RD_FIFO;
            end
         end
      end
   end

endmodule

// ==== hw/burst_ram.sv ====
`timescale 1ns/1ns

module burst_ram #(
   parameter int MEM_AWORDS = mem_pkg::DEF_MEM_AWORDS
) (
   input  logic           wb_clk,
   input  logic           mem_rst,
   mem_cmd_if.executor    cmd,
   input  mem_pkg::data_t wr_data_i,
   input  mem_pkg::sel_t  wr_sel_i,
   input  logic           wr_empty_i,
   output logic           wr_pop_o,
   input  logic           rd_full_i,
   output logic           rd_push_o,
   output mem_pkg::data_t rd_data_o
);

   localparam int QDEPTH = 4;
   localparam int QPW    = $clog2(QDEPTH);

   ////////////////////////////////////////////////////////////
   // command queue
   ////////////////////////////////////////////////////////////
   mem_pkg::mem_cmd_e   q_instr [QDEPTH];
   mem_pkg::blen_t      q_blen  [QDEPTH];
   mem_pkg::byte_addr_t q_addr  [QDEPTH];
   logic [QPW-1:0]      q_wp;
   logic [QPW-1:0]      q_rp;
   logic [QPW:0]        q_cnt;
   logic                q_push;
   logic                q_take;   // next command moves to the engine

   ////////////////////////////////////////////////////////////
   // burst engine
   ////////////////////////////////////////////////////////////
   mem_pkg::data_t        mem [2**MEM_AWORDS];
   logic                  active;     // a burst is running
   mem_pkg::mem_cmd_e     cur_instr;
   mem_pkg::blen_t        left;       // words after the current one
   logic [MEM_AWORDS-1:0] waddr;      // word address, wraps with the array
   logic                  step;       // one word moved this cycle

   // full one entry early, the issuer's cmd_en is a registered pulse
   assign cmd.cmd_full = (q_cnt >= (QPW+1)'(QDEPTH - 1));
   assign q_push = cmd.cmd_en & (q_cnt != (QPW+1)'(QDEPTH));
   assign q_take = ~active & (q_cnt != '0);

   assign wr_pop_o  = active & (cur_instr == mem_pkg::CMD_WRITE) & ~wr_empty_i;
   assign rd_push_o = active & (cur_instr == mem_pkg::CMD_READ) & ~rd_full_i;
   assign rd_data_o = mem[waddr];
   assign step      = wr_pop_o | rd_push_o;

   always_ff @(posedge wb_clk) begin
      if (q_push) begin
         q_instr[q_wp] <= cmd.cmd_instr;
         q_blen[q_wp]  <= cmd.cmd_blen;
         q_addr[q_wp]  <= cmd.cmd_addr;
      end
      if (q_take) begin
         cur_instr <= q_instr[q_rp];
         left      <= q_blen[q_rp];
         waddr     <= q_addr[q_rp][MEM_AWORDS+1:2];  // byte to word address
      end else if (step) begin
         left  <= left - 1'b1;
         waddr <= waddr + 1'b1;
      end
      // merge only the selected byte lanes
      if (wr_pop_o) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_sel_i[b]) mem[waddr][8*b +: 8] <= wr_data_i[8*b +: 8];
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         q_wp   <= '0;
         q_rp   <= '0;
         q_cnt  <= '0;
         active <= 1'b0;
      end else begin
         if (q_push) q_wp <= q_wp + 1'b1;
         if (q_take) q_rp <= q_rp + 1'b1;
         q_cnt <= q_cnt + (QPW+1)'(q_push) - (QPW+1)'(q_take);
         if (q_take) begin
            active <= 1'b1;
         end else if (step && left == '0) begin
            active <= 1'b0;  // last word of the burst
         end
      end
   end

endmodule

// ==== hw/rd_prefetch_fifo.sv ====
`timescale 1ns/1ns

module rd_prefetch_fifo (
   input  logic           wb_clk,
   input  logic           mem_rst,
   input  logic           push_i,
   input  mem_pkg::data_t data_i,
   input  logic           pop_i,
   input  logic           inv_i,
   input  mem_pkg::fcnt_t inv_cnt_i,
   output mem_pkg::data_t data_o,
   output logic           empty_o,
   output logic           full_o,
   output logic           busy_o
);

   localparam int PW = $clog2(mem_pkg::FIFO_DEPTH);

   mem_pkg::data_t dat_mem [mem_pkg::FIFO_DEPTH];
   logic [PW-1:0]  wr_ptr;
   logic [PW-1:0]  rd_ptr;
   mem_pkg::fcnt_t cnt;
   mem_pkg::fcnt_t inv_cnt;   // stale words still to throw away
   logic           inv_nz_d;  // drain active last cycle
   logic           drain;
   logic           do_push;
   logic           do_pop;

   assign full_o  = (cnt == mem_pkg::fcnt_t'(mem_pkg::FIFO_DEPTH));
   assign empty_o = (cnt == '0);
   assign data_o  = dat_mem[rd_ptr];

   // stale words leave one per cycle as soon as they show up
   assign drain   = (inv_cnt != '0) & ~empty_o;
   assign do_push = push_i & ~full_o;
   assign do_pop  = (pop_i | drain) & ~empty_o;

   // held one extra cycle so the head is settled when busy drops
   assign busy_o  = (inv_cnt != '0) | inv_nz_d;

   always_ff @(posedge wb_clk) begin
      if (do_push) dat_mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         cnt      <= '0;
         inv_cnt  <= '0;
         inv_nz_d <= 1'b0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         cnt <= cnt + mem_pkg::fcnt_t'(do_push) - mem_pkg::fcnt_t'(do_pop);
         // a new request adds to whatever is still being dropped
         inv_cnt  <= inv_cnt - mem_pkg::fcnt_t'(drain) + (inv_i ? inv_cnt_i : '0);
         inv_nz_d <= (inv_cnt != '0);
      end
   end

endmodule

// ==== hw/wr_data_fifo.sv ====
`timescale 1ns/1ns

module wr_data_fifo (
   input  logic           wb_clk,
   input  logic           mem_rst,
   input  logic           push_i,
   input  mem_pkg::data_t data_i,
   input  mem_pkg::sel_t  sel_i,
   input  logic           pop_i,
   output mem_pkg::data_t data_o,
   output mem_pkg::sel_t  sel_o,
   output logic           full_o,
   output logic           empty_o
);

   localparam int PW = $clog2(mem_pkg::FIFO_DEPTH);

   mem_pkg::data_t dat_mem [mem_pkg::FIFO_DEPTH];  // write words
   mem_pkg::sel_t  sel_mem [mem_pkg::FIFO_DEPTH];  // their byte lanes
   logic [PW-1:0]  wr_ptr;
   logic [PW-1:0]  rd_ptr;
   mem_pkg::fcnt_t cnt;                           // words held
   logic           do_push;
   logic           do_pop;

   assign full_o  = (cnt == mem_pkg::fcnt_t'(mem_pkg::FIFO_DEPTH));
   assign empty_o = (cnt == '0);
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;
   assign data_o  = dat_mem[rd_ptr];  // head word falls through
   assign sel_o   = sel_mem[rd_ptr];

   always_ff @(posedge wb_clk) begin
      if (do_push) begin
         dat_mem[wr_ptr] <= data_i;
         sel_mem[wr_ptr] <= sel_i;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         cnt <= cnt + mem_pkg::fcnt_t'(do_push) - mem_pkg::fcnt_t'(do_pop);
      end
   end

endmodule

// ==== hw/mem_cmd_if.sv ====
`timescale 1ns/1ns

// burst command group between the bridge FSM and the memory
interface mem_cmd_if;
   logic                cmd_en;     // one-cycle pulse queues a command
   mem_pkg::mem_cmd_e   cmd_instr;
   mem_pkg::blen_t      cmd_blen;   // words minus one
   mem_pkg::byte_addr_t cmd_addr;   // first byte of the burst
   logic                cmd_full;   // no room for one more command

   modport issuer (
      output cmd_en, cmd_instr, cmd_blen, cmd_addr,
      input  cmd_full
   );

   modport executor (
      input  cmd_en, cmd_instr, cmd_blen, cmd_addr,
      output cmd_full
   );
endinterface

// ==== hw/mem_pkg.sv ====
package mem_pkg;

   ////////////////////////////////////////////////////////////
   // sizes and defaults
   ////////////////////////////////////////////////////////////
   localparam int FIFO_DEPTH         = 64;  // words in each data fifo
   localparam int DEF_READ_BURST_LEN = 8;   // words fetched per read-ahead burst
   localparam int DEF_MEM_AWORDS     = 10;  // log2 of memory depth in words

   typedef logic [28:0] byte_addr_t;  // byte address, 512 Mbytes of space
   typedef logic [31:0] data_t;
   typedef logic [3:0]  sel_t;        // one bit per byte lane
   typedef logic [5:0]  blen_t;       // burst length minus one, 1..64 words
   typedef logic [6:0]  fcnt_t;       // fifo fill level, 0..FIFO_DEPTH

   // burst port instructions, both close the row afterwards
   typedef enum logic [2:0] {
      CMD_WRITE = 3'b010,  // write with autoprecharge
      CMD_READ  = 3'b011   // read with autoprecharge
   } mem_cmd_e;

   ////////////////////////////////////////////////////////////
   // bridge control
   ////////////////////////////////////////////////////////////
   typedef enum logic [2:0] {
      ST_RST     = 3'd0,  // wait for the master to close its cycle
      ST_IDLE    = 3'd1,  // first strobe of a block decides the direction
      ST_WR_FIFO = 3'd2,  // collecting write words
      ST_WR_CMD  = 3'd3,  // write burst ready, command queue full
      ST_RD_FIFO = 3'd4,  // serving reads from the read-ahead fifo
      ST_RD_CMD  = 3'd5   // read burst ready, command queue full
   } fsm_state_e;

endpackage
